// File: sources.f
logic/cachePkg.sv
logic/tagRam.sv
logic/tagQuery.sv
logic/lookupArbiter.sv
logic/resultQueue.sv
logic/cacheTagTop.sv
sim/cacheTagChecks_sva.sv
sim/cacheTagTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cacheTagTb
BUILD_DIR ?= build
LOG ?= sim.log
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+100
PASS_TEXT = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	-./$(BUILD_DIR)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/cacheTagTb.sv
module cacheTagTb;
	import cachePkg::*;

	// random phase length and the cycle budget for the whole run
	localparam int randomCycles = 400;
	localparam int testCycles = randomCycles + 200;
	// cycles a drain may wait for outstanding results
	localparam int drainLimit = 40;

	// one expected lookup result
	typedef struct packed
	{
		logic                  hit;
		logic [tagBits-1:0]    tag;
		logic [indexBits-1:0]  index;
		logic [offsetBits-1:0] offset;
	} resultEntry;

	logic                  clock_i;
	logic                  arstN_i;
	logic                  flush_i;
	logic                  lookupValid_i;
	logic [tagBits-1:0]    lookupTag_i;
	logic [indexBits-1:0]  lookupIndex_i;
	logic [offsetBits-1:0] lookupOffset_i;
	logic                  lookupReady_o;
	logic                  fillValid_i;
	logic [tagBits-1:0]    fillTag_i;
	logic [indexBits-1:0]  fillIndex_i;
	logic                  fillReady_o;
	logic                  resultValid_o;
	logic                  resultReady_i;
	logic                  resultHit_o;
	logic [tagBits-1:0]    resultTag_o;
	logic [indexBits-1:0]  resultIndex_o;
	logic [offsetBits-1:0] resultOffset_o;

	// reference model of the tag store and the results owed
	logic [tagBits-1:0] modelTag [numLines];
	logic               modelValid [numLines];
	resultEntry         expectedQ [$];
	memOp               lastAccept = opIdle;
	// transfers seen at the last edge
	logic               lookupTaken = 1'b0;
	logic               fillTaken = 1'b0;
	int                 liveCycles = 0;
	int                 errorCount = 0;
	int                 checkCount = 0;

	cacheTagTop uut (.*);

	initial
		forever #2 clock_i = ~clock_i;

	task automatic reportMismatch(input string signalName, input logic [31:0] expected,
		input logic [31:0] actual);
		errorCount++;
		$display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, signalName,
			expected, actual);
	endtask

	task automatic printTotals();
		$display("errors: %0d model, %0d assertion; results checked: %0d", errorCount,
			uut.checks.failCount, checkCount);
	endtask

	////////////////////////////////////////
	// monitor and reference model
	////////////////////////////////////////

	// sampled mid cycle, inputs only move just after the rising edge
	always @(negedge clock_i)
	begin
		resultEntry entry;
		logic wantLookup;
		lookupTaken = lookupValid_i && lookupReady_o;
		fillTaken = fillValid_i && fillReady_o;
		if (arstN_i)
		begin
			// nothing may move in the first cycle out of reset
			if (liveCycles == 0 && (lookupReady_o || fillReady_o || resultValid_o))
			begin
				errorCount++;
				$display("handshake output high in the first cycle after reset at %0t", $time);
			end
			// every credit in use, lookup port has to stall
			if (expectedQ.size() >= queueDepth && lookupReady_o)
				reportMismatch("lookupReady_o", 0, 1);
			// both contending, the port not served last time wins
			if (lookupValid_i && fillValid_i && !flush_i && liveCycles > 0
				&& expectedQ.size() < queueDepth)
			begin
				wantLookup = (lastAccept != opLookup);
				if (lookupReady_o != wantLookup)
					reportMismatch("lookupReady_o", 32'(wantLookup), 32'(lookupReady_o));
				if (fillReady_o == wantLookup)
					reportMismatch("fillReady_o", 32'(!wantLookup), 32'(fillReady_o));
			end
			if (resultValid_o && resultReady_i)
			begin
				if (expectedQ.size() == 0)
				begin
					errorCount++;
					$display("result at %0t arrived with no lookup waiting for it", $time);
				end
				else
				begin
					entry = expectedQ.pop_front();
					checkCount++;
					if (resultHit_o !== entry.hit)
						reportMismatch("resultHit_o", 32'(entry.hit), 32'(resultHit_o));
					if (resultTag_o !== entry.tag)
						reportMismatch("resultTag_o", 32'(entry.tag), 32'(resultTag_o));
					if (resultIndex_o !== entry.index)
						reportMismatch("resultIndex_o", 32'(entry.index), 32'(resultIndex_o));
					if (resultOffset_o !== entry.offset)
						reportMismatch("resultOffset_o", 32'(entry.offset), 32'(resultOffset_o));
				end
			end
			// hit is decided by the model state at acceptance
			if (lookupTaken)
			begin
				entry.hit = modelValid[lookupIndex_i] && (modelTag[lookupIndex_i] == lookupTag_i);
				entry.tag = lookupTag_i;
				entry.index = lookupIndex_i;
				entry.offset = lookupOffset_i;
				expectedQ.push_back(entry);
				lastAccept = opLookup;
			end
			if (fillTaken)
			begin
				modelTag[fillIndex_i] = fillTag_i;
				modelValid[fillIndex_i] = 1'b1;
				lastAccept = opFill;
			end
			// flush drops every result still owed
			if (flush_i)
				expectedQ.delete();
			liveCycles++;
		end
	end

	////////////////////////////////////////
	// request drivers
	////////////////////////////////////////

	task automatic pickLookup(input int tagRange, input int indexRange);
		lookupTag_i = tagBits'($urandom % tagRange);
		lookupIndex_i = indexBits'($urandom % indexRange);
		lookupOffset_i = offsetBits'($urandom);
	endtask

	task automatic pickFill(input int tagRange, input int indexRange);
		fillTag_i = tagBits'($urandom % tagRange);
		fillIndex_i = indexBits'($urandom % indexRange);
	endtask

	task automatic sendLookup(input logic [tagBits-1:0] tag, input logic [indexBits-1:0] index,
		input logic [offsetBits-1:0] offset);
		lookupValid_i = 1'b1;
		lookupTag_i = tag;
		lookupIndex_i = index;
		lookupOffset_i = offset;
		@(posedge clock_i);
		while (!lookupTaken)
			@(posedge clock_i);
		#1;
		lookupValid_i = 1'b0;
	endtask

	task automatic sendFill(input logic [tagBits-1:0] tag, input logic [indexBits-1:0] index);
		fillValid_i = 1'b1;
		fillTag_i = tag;
		fillIndex_i = index;
		@(posedge clock_i);
		while (!fillTaken)
			@(posedge clock_i);
		#1;
		fillValid_i = 1'b0;
	endtask

	task automatic drainResults();
		int waited;
		waited = 0;
		resultReady_i = 1'b1;
		while (expectedQ.size() != 0 && waited < drainLimit)
		begin
			@(posedge clock_i);
			#1;
			waited++;
		end
		if (expectedQ.size() != 0)
		begin
			errorCount++;
			$display("%0d lookups got no result within %0d cycles", expectedQ.size(), drainLimit);
			expectedQ.delete();
		end
	endtask

	// both ports held valid, new fields after each transfer
	task automatic holdBoth(input int transfers);
		int seen;
		seen = 0;
		resultReady_i = 1'b1;
		lookupValid_i = 1'b1;
		fillValid_i = 1'b1;
		pickLookup(4, 8);
		pickFill(4, 8);
		while (seen < transfers)
		begin
			@(posedge clock_i);
			#1;
			if (lookupTaken)
			begin
				seen++;
				pickLookup(4, 8);
			end
			if (fillTaken)
			begin
				seen++;
				pickFill(4, 8);
			end
		end
		lookupValid_i = 1'b0;
		fillValid_i = 1'b0;
	endtask

	task automatic randomTraffic(input int cycles);
		repeat (cycles)
		begin
			// a new request only once the held one was taken
			if (!lookupValid_i || lookupTaken)
			begin
				lookupValid_i = ($urandom % 100) < 60;
				pickLookup(4, 8);
			end
			if (!fillValid_i || fillTaken)
			begin
				fillValid_i = ($urandom % 100) < 30;
				pickFill(4, 8);
			end
			resultReady_i = ($urandom % 100) < 50;
			flush_i = ($urandom % 100) < 3;
			@(posedge clock_i);
			#1;
		end
		flush_i = 1'b0;
		resultReady_i = 1'b1;
		// let held requests finish before dropping them
		while (lookupValid_i || fillValid_i)
		begin
			if (lookupTaken)
				lookupValid_i = 1'b0;
			if (fillTaken)
				fillValid_i = 1'b0;
			if (lookupValid_i || fillValid_i)
			begin
				@(posedge clock_i);
				#1;
			end
		end
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		void'($urandom(17));
		clock_i = 1'b0;
		arstN_i = 1'b0;
		flush_i = 1'b0;
		lookupValid_i = 1'b0;
		lookupTag_i = '0;
		lookupIndex_i = '0;
		lookupOffset_i = '0;
		fillValid_i = 1'b0;
		fillTag_i = '0;
		fillIndex_i = '0;
		resultReady_i = 1'b1;
		for (int i = 0; i < numLines; i++)
			modelValid[i] = 1'b0;
		repeat (10) @(posedge clock_i);
		#1;
		arstN_i = 1'b1;
		repeat (3) @(posedge clock_i);
		#1;
		// fresh after reset, everything misses
		repeat (8)
			sendLookup(tagBits'($urandom), indexBits'($urandom), offsetBits'($urandom));
		drainResults();
		// fill then hit, other tag on the same line misses
		sendFill(21'h1abcd, 6'd5);
		sendLookup(21'h1abcd, 6'd5, 5'd3);
		sendLookup(21'h0abcd, 6'd5, 5'd3);
		// refill replaces the old tag
		sendFill(21'h00042, 6'd5);
		sendLookup(21'h1abcd, 6'd5, 5'd9);
		sendLookup(21'h00042, 6'd5, 5'd9);
		drainResults();
		holdBoth(12);
		drainResults();
		randomTraffic(randomCycles);
		drainResults();
		// flush with lookups queued and in flight
		sendFill(21'h00155, 6'd40);
		resultReady_i = 1'b0;
		repeat (3)
			sendLookup(tagBits'($urandom % 4), indexBits'($urandom % 8), offsetBits'($urandom));
		flush_i = 1'b1;
		@(posedge clock_i);
		#1;
		flush_i = 1'b0;
		resultReady_i = 1'b1;
		sendLookup(21'h00155, 6'd40, 5'd1);
		sendLookup(21'h00042, 6'd40, 5'd2);
		drainResults();
		// a stray result would still show up here
		repeat (4) @(posedge clock_i);
		printTotals();
		if (errorCount == 0 && uut.checks.failCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog, twice the expected run length
	initial
	begin
		#(testCycles * 4 * 2);
		$display("timeout: run still going after %0d cycles", testCycles * 2);
		printTotals();
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: sim/cacheTagChecks_sva.sv
module cacheTagChecks (
	input logic                            clock_i,
	input logic                            arstN_i,
	input logic                            flush_i,
	input logic                            lookupValid_i,
	input logic                            lookupReady_i,
	input logic                            fillValid_i,
	input logic                            fillReady_i,
	input logic                            resultValid_i,
	input logic [cachePkg::creditBits-1:0] credits_i
);
	import cachePkg::*;

	// assertion failures so far
	int failCount = 0;

	////////////////////////////////////////
	// arbiter rules
	////////////////////////////////////////

	// single port memory, one operation per edge
	oneIssue: assert property (@(posedge clock_i) disable iff (!arstN_i)
		!(lookupValid_i && lookupReady_i && fillValid_i && fillReady_i))
	else
	begin
		failCount++;
		$error("lookup and fill accepted on the same edge");
	end

	// more credits than queue slots would allow an overflow
	creditLimit: assert property (@(posedge clock_i) disable iff (!arstN_i)
		credits_i <= creditBits'(queueDepth))
	else
	begin
		failCount++;
		$error("credit counter above the queue depth");
	end

	// queue is empty right after a flush
	flushEmpties: assert property (@(posedge clock_i) disable iff (!arstN_i)
		flush_i |=> !resultValid_i)
	else
	begin
		failCount++;
		$error("result valid in the cycle after a flush");
	end

endmodule

bind cacheTagTop cacheTagChecks checks (
	.clock_i       (clock_i),
	.arstN_i       (arstN_i),
	.flush_i       (flush_i),
	.lookupValid_i (lookupValid_i),
	.lookupReady_i (lookupReady_o),
	.fillValid_i   (fillValid_i),
	.fillReady_i   (fillReady_o),
	.resultValid_i (resultValid_o),
	.credits_i     (arbiter.credits)
);

// File: logic/cacheTagTop.sv
module cacheTagTop (
	input  logic                            clock_i,
	input  logic                            arstN_i,
	input  logic                            flush_i,
	// lookup request
	input  logic                            lookupValid_i,
	input  logic [cachePkg::tagBits-1:0]    lookupTag_i,
	input  logic [cachePkg::indexBits-1:0]  lookupIndex_i,
	input  logic [cachePkg::offsetBits-1:0] lookupOffset_i,
	output logic                            lookupReady_o,
	// fill request
	input  logic                            fillValid_i,
	input  logic [cachePkg::tagBits-1:0]    fillTag_i,
	input  logic [cachePkg::indexBits-1:0]  fillIndex_i,
	output logic                            fillReady_o,
	// lookup result
	output logic                            resultValid_o,
	input  logic                            resultReady_i,
	output logic                            resultHit_o,
	output logic [cachePkg::tagBits-1:0]    resultTag_o,
	output logic [cachePkg::indexBits-1:0]  resultIndex_o,
	output logic [cachePkg::offsetBits-1:0] resultOffset_o
);
	import cachePkg::*;

	// arbiter to query stage
	memOp                  issueOp;
	logic [tagBits-1:0]    issueTag;
	logic [indexBits-1:0]  issueIndex;
	logic [offsetBits-1:0] issueOffset;
	// query stage to queue
	logic                  pushValid;
	logic                  pushHit;
	logic [tagBits-1:0]    pushTag;
	logic [indexBits-1:0]  pushIndex;
	logic [offsetBits-1:0] pushOffset;
	// credit return
	logic                  popped;

	lookupArbiter arbiter (
		.clock_i (clock_i), .arstN_i (arstN_i), .flush_i (flush_i),
		.lookupValid_i (lookupValid_i), .lookupTag_i (lookupTag_i),
		.lookupIndex_i (lookupIndex_i), .lookupOffset_i (lookupOffset_i),
		.lookupReady_o (lookupReady_o),
		.fillValid_i (fillValid_i), .fillTag_i (fillTag_i),
		.fillIndex_i (fillIndex_i), .fillReady_o (fillReady_o),
		.popped_i (popped),
		.issueOp_o (issueOp), .issueTag_o (issueTag),
		.issueIndex_o (issueIndex), .issueOffset_o (issueOffset)
	);

	tagQuery query (
		.clock_i (clock_i), .arstN_i (arstN_i), .flush_i (flush_i),
		.issueOp_i (issueOp), .issueTag_i (issueTag),
		.issueIndex_i (issueIndex), .issueOffset_i (issueOffset),
		.pushValid_o (pushValid), .pushHit_o (pushHit), .pushTag_o (pushTag),
		.pushIndex_o (pushIndex), .pushOffset_o (pushOffset)
	);

	resultQueue results (
		.clock_i (clock_i), .arstN_i (arstN_i), .flush_i (flush_i),
		.pushValid_i (pushValid), .pushHit_i (pushHit), .pushTag_i (pushTag),
		.pushIndex_i (pushIndex), .pushOffset_i (pushOffset),
		.resultValid_o (resultValid_o), .resultReady_i (resultReady_i),
		.resultHit_o (resultHit_o), .resultTag_o (resultTag_o),
		.resultIndex_o (resultIndex_o), .resultOffset_o (resultOffset_o),
		.popped_o (popped)
	);

endmodule

// File: logic/resultQueue.sv
module resultQueue (
	input  logic                            clock_i,
	input  logic                            arstN_i,
	input  logic                            flush_i,
	// write side, never refused thanks to the arbiter credits
	input  logic                            pushValid_i,
	input  logic                            pushHit_i,
	input  logic [cachePkg::tagBits-1:0]    pushTag_i,
	input  logic [cachePkg::indexBits-1:0]  pushIndex_i,
	input  logic [cachePkg::offsetBits-1:0] pushOffset_i,
	// read side
	output logic                            resultValid_o,
	input  logic                            resultReady_i,
	output logic                            resultHit_o,
	output logic [cachePkg::tagBits-1:0]    resultTag_o,
	output logic [cachePkg::indexBits-1:0]  resultIndex_o,
	output logic [cachePkg::offsetBits-1:0] resultOffset_o,
	output logic                            popped_o
);
	import cachePkg::*;

	// entry storage, split by field
	logic                  hitMem    [queueDepth];
	logic [tagBits-1:0]    tagMem    [queueDepth];
	logic [indexBits-1:0]  indexMem  [queueDepth];
	logic [offsetBits-1:0] offsetMem [queueDepth];

	logic [ptrBits-1:0]    wrPtr;
	logic [ptrBits-1:0]    rdPtr;
	logic [creditBits-1:0] count;
	logic                  doPush;

	// pushes arriving during a flush belong to discarded lookups
	assign doPush = pushValid_i && !flush_i;

	// show-ahead, head entry sits on the port
	// nothing leaves while flushing
	assign resultValid_o = (count != '0) && !flush_i;
	assign popped_o = resultValid_o && resultReady_i;
	assign resultHit_o = hitMem[rdPtr];
	assign resultTag_o = tagMem[rdPtr];
	assign resultIndex_o = indexMem[rdPtr];
	assign resultOffset_o = offsetMem[rdPtr];

	always_ff @(posedge clock_i)
	begin
		if (doPush)
		begin
			hitMem[wrPtr] <= pushHit_i;
			tagMem[wrPtr] <= pushTag_i;
			indexMem[wrPtr] <= pushIndex_i;
			offsetMem[wrPtr] <= pushOffset_i;
		end
	end

	////////////////////////////////////////
	// pointers and fill level
	////////////////////////////////////////

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (flush_i)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// pointers wrap on their own, depth is a power of two
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (popped_o)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, popped_o})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/lookupArbiter.sv
module lookupArbiter (
	input  logic                            clock_i,
	input  logic                            arstN_i,
	input  logic                            flush_i,
	// lookup port
	input  logic                            lookupValid_i,
	input  logic [cachePkg::tagBits-1:0]    lookupTag_i,
	input  logic [cachePkg::indexBits-1:0]  lookupIndex_i,
	input  logic [cachePkg::offsetBits-1:0] lookupOffset_i,
	output logic                            lookupReady_o,
	// fill port
	input  logic                            fillValid_i,
	input  logic [cachePkg::tagBits-1:0]    fillTag_i,
	input  logic [cachePkg::indexBits-1:0]  fillIndex_i,
	output logic                            fillReady_o,
	// one credit back per result leaving the queue
	input  logic                            popped_i,
	// issued memory operation
	output cachePkg::memOp                  issueOp_o,
	output logic [cachePkg::tagBits-1:0]    issueTag_o,
	output logic [cachePkg::indexBits-1:0]  issueIndex_o,
	output logic [cachePkg::offsetBits-1:0] issueOffset_o
);
	import cachePkg::*;

	// last port granted, opIdle until the first grant
	memOp lastGrant;
	// free result slots not yet claimed by a lookup
	logic [creditBits-1:0] credits;
	// held low through reset and the first edge after release
	logic started;
	logic lookupAllowed;
	logic fillAllowed;
	logic grantLookup;
	logic grantFill;

	////////////////////////////////////////
	// arbitration
	////////////////////////////////////////

	assign fillAllowed = started && !flush_i;
	// no lookup without a guaranteed queue slot
	assign lookupAllowed = fillAllowed && (credits != '0);

	// lookup yields only when fill is competing and lookup won last time
	assign lookupReady_o = lookupAllowed
		&& !(fillValid_i && fillAllowed && (lastGrant == opLookup));
	// fill yields when a lookup is competing and fill does not have the turn
	assign fillReady_o = fillAllowed
		&& !(lookupValid_i && lookupAllowed && (lastGrant != opLookup));

	assign grantLookup = lookupValid_i && lookupReady_o;
	assign grantFill = fillValid_i && fillReady_o;

	// at most one grant per cycle, so the single port never collides
	always_comb
	begin
		issueOp_o = opIdle;
		if (grantLookup)
			issueOp_o = opLookup;
		else if (grantFill)
			issueOp_o = opFill;
	end

	// fill write data rides on the tag lines
	assign issueTag_o = grantFill ? fillTag_i : lookupTag_i;
	assign issueIndex_o = grantFill ? fillIndex_i : lookupIndex_i;
	assign issueOffset_o = lookupOffset_i;

	////////////////////////////////////////
	// grant history and credits
	////////////////////////////////////////

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			started <= 1'b0;
			lastGrant <= opIdle;
			credits <= creditBits'(queueDepth);
		end
		else
		begin
			started <= 1'b1;
			if (issueOp_o != opIdle)
				lastGrant <= issueOp_o;
			// flush empties the queue and pipeline, every slot comes back
			if (flush_i)
				credits <= creditBits'(queueDepth);
			else
			begin
				case ({grantLookup, popped_i})
					2'b10: credits <= credits - 1'b1;
					2'b01: credits <= credits + 1'b1;
					default: credits <= credits;
				endcase
			end
		end
	end

endmodule

// File: logic/tagQuery.sv
module tagQuery (
	input  logic                            clock_i,
	input  logic                            arstN_i,
	input  logic                            flush_i,
	// operation from the arbiter
	input  cachePkg::memOp                  issueOp_i,
	input  logic [cachePkg::tagBits-1:0]    issueTag_i,
	input  logic [cachePkg::indexBits-1:0]  issueIndex_i,
	input  logic [cachePkg::offsetBits-1:0] issueOffset_i,
	// result towards the queue
	output logic                            pushValid_o,
	output logic                            pushHit_o,
	output logic [cachePkg::tagBits-1:0]    pushTag_o,
	output logic [cachePkg::indexBits-1:0]  pushIndex_o,
	output logic [cachePkg::offsetBits-1:0] pushOffset_o
);
	import cachePkg::*;

	// bypass stage, request fields wait here while the memory reads
	logic [tagBits-1:0]    bypassTag;
	logic [indexBits-1:0]  bypassIndex;
	logic [offsetBits-1:0] bypassOffset;
	logic                  bypassLookup;

	// memory read data, valid one cycle after the lookup issue
	logic [tagBits-1:0] storedTag;
	logic               storedValid;
	logic               lineHit;

	// fill reuses the issue tag lines as write data
	tagRam tagMemory (
		.clock_i   (clock_i),
		.arstN_i   (arstN_i),
		.op_i      (issueOp_i),
		.addr_i    (issueIndex_i),
		.wrTag_i   (issueTag_i),
		.rdTag_o   (storedTag),
		.rdValid_o (storedValid)
	);

	// hit needs both a live line and a matching tag
	assign lineHit = storedValid && (storedTag == bypassTag);

	////////////////////////////////////////
	// stage payload
	////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		// capture only on lookups, fills leave the stage untouched
		if (issueOp_i == opLookup)
		begin
			bypassTag <= issueTag_i;
			bypassIndex <= issueIndex_i;
			bypassOffset <= issueOffset_i;
		end
		// compare stage, echo the request beside the result
		if (bypassLookup)
		begin
			pushHit_o <= lineHit;
			pushTag_o <= bypassTag;
			pushIndex_o <= bypassIndex;
			pushOffset_o <= bypassOffset;
		end
	end

	////////////////////////////////////////
	// stage flags
	////////////////////////////////////////

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			bypassLookup <= 1'b0;
			pushValid_o <= 1'b0;
		end
		else if (flush_i)
		begin
			// drop whatever is in flight
			bypassLookup <= 1'b0;
			pushValid_o <= 1'b0;
		end
		else
		begin
			bypassLookup <= (issueOp_i == opLookup);
			pushValid_o <= bypassLookup;
		end
	end

endmodule

// File: logic/tagRam.sv
module tagRam (
	input  logic                           clock_i,
	input  logic                           arstN_i,
	input  cachePkg::memOp                 op_i,
	input  logic [cachePkg::indexBits-1:0] addr_i,
	input  logic [cachePkg::tagBits-1:0]   wrTag_i,
	output logic [cachePkg::tagBits-1:0]   rdTag_o,
	output logic                           rdValid_o
);
	import cachePkg::*;

	// tag storage, contents are don't care until the valid bit is set
	logic [tagBits-1:0] tagMem [numLines];
	// one valid bit per line, kept apart from the tag array
	logic [numLines-1:0] lineValid;

	////////////////////////////////////////
	// tag array
	////////////////////////////////////////

	// single port: either a write or a registered read per edge
	always_ff @(posedge clock_i)
	begin
		if (op_i == opFill)
			tagMem[addr_i] <= wrTag_i;
		// read data only moves on a lookup so it stays paired with the query stage
		if (op_i == opLookup)
			rdTag_o <= tagMem[addr_i];
	end

	////////////////////////////////////////
	// valid bits
	////////////////////////////////////////

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			lineValid <= '0;
			rdValid_o <= 1'b0;
		end
		else
		begin
			// a fill always marks the line valid
			if (op_i == opFill)
				lineValid[addr_i] <= 1'b1;
			if (op_i == opLookup)
				rdValid_o <= lineValid[addr_i];
		end
	end

endmodule

// File: logic/cachePkg.sv
package cachePkg;

	////////////////////////////////////////
	// address layout
	////////////////////////////////////////

	// full byte address width
	localparam int addrBits = 32;
	// byte offset inside a line
	localparam int offsetBits = 5;
	// line select
	localparam int indexBits = 6;
	// whatever is left over is the tag
	localparam int tagBits = addrBits - indexBits - offsetBits;
	// direct mapped, one tag per index
	localparam int numLines = 2 ** indexBits;

	////////////////////////////////////////
	// result queue sizing
	////////////////////////////////////////

	// entries in the result FIFO, also the lookup credit limit
	localparam int queueDepth = 4;
	// FIFO pointer width, depth is a power of two so pointers wrap
	localparam int ptrBits = $clog2(queueDepth);
	// counters must hold 0..queueDepth inclusive
	localparam int creditBits = $clog2(queueDepth + 1);

	// operation presented to the single port tag memory in a cycle
	typedef enum logic [1:0]
	{
		opIdle   = 2'd0,
		opLookup = 2'd1,
		opFill   = 2'd2
	} memOp;

endpackage
